//--- design/dtim_params.svh
`ifndef DTIM_PARAMS_SVH
`define DTIM_PARAMS_SVH

// Word banks, a power of two. Address bits 3..2 pick the bank.
`define DTIM_BANKS 4

// Entries in each bank. The address bits above the bank bits pick the index.
`define DTIM_SETS 16

// Cacheable window, from the base up to but not including the top.
`define DTIM_BASE_ADDR 32'h0000_0000
`define DTIM_TOP_ADDR 32'h0001_0000

`endif

//--- design/dtim_pkg.sv
`include "dtim_params.svh"

package dtim_pkg;

  localparam int bank_w = $clog2(`DTIM_BANKS);
  localparam int index_w = $clog2(`DTIM_SETS);
  localparam int tag_w = 32 - 2 - bank_w - index_w;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0] strb_t;
  typedef logic [bank_w-1:0] bank_t;
  typedef logic [index_w-1:0] index_t;
  typedef logic [tag_w-1:0] tag_t;

  // Lock, dirty, tag and data from the top bit down.
  typedef logic [tag_w+33:0] entry_t;

  typedef enum logic [1:0] {
    st_hit,
    st_fill,
    st_bypass,
    st_flush
  } ctrl_state_t;

endpackage

//--- design/dtim_ram.sv
`include "dtim_params.svh"

module dtim_ram (
  input  logic             clock,
  input  logic             wen,
  input  dtim_pkg::index_t waddr,
  input  dtim_pkg::entry_t wdata,
  input  dtim_pkg::index_t raddr,
  output dtim_pkg::entry_t rdata
);
  import dtim_pkg::*;

  entry_t mem [`DTIM_SETS];
  index_t raddr_q;

  always_ff @(posedge clock) begin
    raddr_q <= raddr;
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  assign rdata = mem[raddr_q]; // One cycle after the address.

endmodule

//--- design/dtim_ctrl.sv
`include "dtim_params.svh"

module dtim_ctrl (
  input  logic             clock,
  input  logic             reset,
  input  logic             cpu_valid,
  input  logic             cpu_fence,
  input  dtim_pkg::addr_t  cpu_addr,
  input  dtim_pkg::word_t  cpu_wdata,
  input  dtim_pkg::strb_t  cpu_wstrb,
  output dtim_pkg::word_t  cpu_rdata,
  output logic             cpu_ready,
  output logic             mem_valid,
  output dtim_pkg::addr_t  mem_addr,
  output dtim_pkg::word_t  mem_wdata,
  output dtim_pkg::strb_t  mem_wstrb,
  input  dtim_pkg::word_t  mem_rdata,
  input  logic             mem_ready,
  output logic             bank_wen [`DTIM_BANKS],
  output dtim_pkg::index_t bank_waddr [`DTIM_BANKS],
  output dtim_pkg::entry_t bank_wdata [`DTIM_BANKS],
  output dtim_pkg::index_t bank_raddr [`DTIM_BANKS],
  input  dtim_pkg::entry_t bank_rdata [`DTIM_BANKS]
);
  import dtim_pkg::*;

  localparam int walk_w = index_w + bank_w;

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  bank_t  cpu_bank;
  index_t cpu_index;

  logic   req_valid;
  logic   req_fence;
  logic   req_store;
  addr_t  req_addr;
  word_t  req_wdata;
  strb_t  req_wstrb;
  tag_t   req_tag;
  index_t req_index;
  bank_t  req_bank;

  entry_t hit_entry;
  logic   hit_lock;
  tag_t   hit_tag;
  word_t  hit_data;
  logic   in_window;

  index_t walk_index_q;
  index_t walk_index_d;
  bank_t  walk_bank_q;
  bank_t  walk_bank_d;
  logic   walk_adv;
  logic   walk_last;
  logic   walk_lock;
  logic   walk_dirty;
  tag_t   walk_tag;
  word_t  walk_data;

  logic   mem_launch;
  addr_t  mem_addr_d;
  word_t  mem_wdata_d;
  strb_t  mem_wstrb_d;

  logic   entry_wen;
  entry_t entry_wdata;

  function automatic word_t merge_bytes(word_t old_word, word_t new_word, strb_t strb);
    word_t merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

  assign cpu_bank = cpu_addr[2 +: bank_w];
  assign cpu_index = cpu_addr[2 + bank_w +: index_w];

  always_ff @(posedge clock) begin
    if (!reset) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= cpu_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (cpu_valid) begin
      req_fence <= cpu_fence;
      req_addr <= cpu_addr;
      req_wdata <= cpu_wdata;
      req_wstrb <= cpu_wstrb;
      req_tag <= cpu_addr[31 -: tag_w];
      req_index <= cpu_index;
      req_bank <= cpu_bank;
    end
  end

  assign req_store = |req_wstrb;

  // The selected bank answers in the cycle after the request was taken.
  assign hit_entry = bank_rdata[req_bank];
  assign hit_lock = hit_entry[tag_w + 33];
  assign hit_tag = hit_entry[32 +: tag_w];
  assign hit_data = hit_entry[31:0];
  assign in_window = (req_addr - `DTIM_BASE_ADDR) < (`DTIM_TOP_ADDR - `DTIM_BASE_ADDR);

  assign {walk_lock, walk_dirty, walk_tag, walk_data} = bank_rdata[walk_bank_q];
  assign walk_last = &{walk_index_q, walk_bank_q};

  always_comb begin
    state_d = state_q;
    cpu_ready = 1'b0;
    cpu_rdata = '0;
    mem_launch = 1'b0;
    mem_addr_d = req_addr;
    mem_wdata_d = req_wdata;
    mem_wstrb_d = req_wstrb;
    entry_wen = 1'b0;
    entry_wdata = {1'b1, req_store, req_tag, merge_bytes(hit_data, req_wdata, req_wstrb)};
    walk_adv = 1'b0;
    case (state_q)
      st_hit: begin
        if (req_valid) begin
          if (req_fence) begin
            state_d = st_flush;
          end else if (!in_window || (hit_lock && hit_tag != req_tag)) begin
            state_d = st_bypass; // Held by another tag, so no eviction.
            mem_launch = 1'b1;
          end else if (!hit_lock) begin
            state_d = st_fill;
            mem_launch = 1'b1;
            mem_addr_d = {req_addr[31:2], 2'b00};
            mem_wstrb_d = '0;
          end else begin
            cpu_ready = 1'b1;
            cpu_rdata = req_store ? '0 : hit_data;
            entry_wen = req_store;
          end
        end
      end
      st_fill: begin
        entry_wdata = {1'b1, req_store, req_tag, merge_bytes(mem_rdata, req_wdata, req_wstrb)};
        if (mem_ready) begin
          state_d = st_hit;
          cpu_ready = 1'b1;
          cpu_rdata = req_store ? '0 : mem_rdata;
          entry_wen = 1'b1;
        end
      end
      st_bypass: begin
        if (mem_ready) begin
          state_d = st_hit;
          cpu_ready = 1'b1;
          cpu_rdata = req_store ? '0 : mem_rdata;
        end
      end
      st_flush: begin
        mem_addr_d = {walk_tag, walk_index_q, walk_bank_q, 2'b00};
        mem_wdata_d = walk_data;
        mem_wstrb_d = '1;
        if (mem_valid) begin
          walk_adv = mem_ready;
        end else if (walk_lock && walk_dirty) begin
          mem_launch = 1'b1; // Write back before the entry is cleared.
        end else begin
          walk_adv = 1'b1;
        end
        if (walk_adv && walk_last) begin
          state_d = st_hit;
          cpu_ready = 1'b1;
        end
      end
      default: begin
        state_d = st_hit;
      end
    endcase
  end

  // Bank walk order is bank first, then index.
  always_comb begin
    {walk_index_d, walk_bank_d} = {walk_index_q, walk_bank_q};
    if (walk_adv) begin
      {walk_index_d, walk_bank_d} = {walk_index_q, walk_bank_q} + walk_w'(1);
    end
  end

  always_comb begin
    for (int b = 0; b < `DTIM_BANKS; b++) begin
      bank_wen[b] = 1'b0;
      bank_waddr[b] = req_index;
      bank_wdata[b] = entry_wdata;
      bank_raddr[b] = walk_index_d;
    end
    if (state_q == st_flush) begin
      for (int b = 0; b < `DTIM_BANKS; b++) begin
        bank_waddr[b] = walk_index_q;
        bank_wdata[b] = '0;
      end
      bank_wen[walk_bank_q] = walk_adv;
    end else begin
      bank_wen[req_bank] = entry_wen;
      if (cpu_valid) begin
        bank_raddr[cpu_bank] = cpu_index;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= st_hit;
      walk_index_q <= '0;
      walk_bank_q <= '0;
      mem_valid <= 1'b0;
    end else begin
      state_q <= state_d;
      walk_index_q <= walk_index_d;
      walk_bank_q <= walk_bank_d;
      if (mem_launch) begin
        mem_valid <= 1'b1;
      end else if (mem_ready) begin
        mem_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (mem_launch) begin
      mem_addr <= mem_addr_d;
      mem_wdata <= mem_wdata_d;
      mem_wstrb <= mem_wstrb_d;
    end
  end

endmodule

//--- design/dtim.sv
`include "dtim_params.svh"

module dtim (
  input  logic            clock,
  input  logic            reset,
  input  logic            cpu_valid,
  input  logic            cpu_fence,
  input  dtim_pkg::addr_t cpu_addr,
  input  dtim_pkg::word_t cpu_wdata,
  input  dtim_pkg::strb_t cpu_wstrb,
  output dtim_pkg::word_t cpu_rdata,
  output logic            cpu_ready,
  output logic            mem_valid,
  output dtim_pkg::addr_t mem_addr,
  output dtim_pkg::word_t mem_wdata,
  output dtim_pkg::strb_t mem_wstrb,
  input  dtim_pkg::word_t mem_rdata,
  input  logic            mem_ready
);
  import dtim_pkg::*;

  logic   bank_wen [`DTIM_BANKS];
  index_t bank_waddr [`DTIM_BANKS];
  entry_t bank_wdata [`DTIM_BANKS];
  index_t bank_raddr [`DTIM_BANKS];
  entry_t bank_rdata [`DTIM_BANKS];

  for (genvar b = 0; b < `DTIM_BANKS; b++) begin : gen_bank
    dtim_ram bank_i (
      .clock (clock),
      .wen   (bank_wen[b]),
      .waddr (bank_waddr[b]),
      .wdata (bank_wdata[b]),
      .raddr (bank_raddr[b]),
      .rdata (bank_rdata[b])
    );
  end

  dtim_ctrl ctrl_i (
    .clock      (clock),
    .reset      (reset),
    .cpu_valid  (cpu_valid),
    .cpu_fence  (cpu_fence),
    .cpu_addr   (cpu_addr),
    .cpu_wdata  (cpu_wdata),
    .cpu_wstrb  (cpu_wstrb),
    .cpu_rdata  (cpu_rdata),
    .cpu_ready  (cpu_ready),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .mem_rdata  (mem_rdata),
    .mem_ready  (mem_ready),
    .bank_wen   (bank_wen),
    .bank_waddr (bank_waddr),
    .bank_wdata (bank_wdata),
    .bank_raddr (bank_raddr),
    .bank_rdata (bank_rdata)
  );

endmodule

//--- sim/dtim_sva.sv
module dtim_sva (
  input logic            clock,
  input logic            reset,
  input logic            mem_valid,
  input logic            mem_ready,
  input dtim_pkg::addr_t mem_addr,
  input dtim_pkg::word_t mem_wdata,
  input dtim_pkg::strb_t mem_wstrb,
  input logic            cpu_ready
);

  a_ready_needs_valid: assert property (@(posedge clock) disable iff (!reset)
    mem_ready |-> mem_valid)
    else $error("mem_ready high while mem_valid is low");

  // The request must hold until the memory takes it.
  a_mem_stable: assert property (@(posedge clock) disable iff (!reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) &&
    $stable(mem_wdata) && $stable(mem_wstrb))
    else $error("memory request changed before mem_ready");

  a_ready_pulse: assert property (@(posedge clock) disable iff (!reset)
    cpu_ready |=> !cpu_ready)
    else $error("cpu_ready held for more than one cycle");

endmodule

bind dtim dtim_sva sva_i (
  .clock     (clock),
  .reset     (reset),
  .mem_valid (mem_valid),
  .mem_ready (mem_ready),
  .mem_addr  (mem_addr),
  .mem_wdata (mem_wdata),
  .mem_wstrb (mem_wstrb),
  .cpu_ready (cpu_ready)
);

//--- sim/dtim_tb.sv
`include "dtim_params.svh"

module dtim_tb;
  import dtim_pkg::*;

  logic  clock = 1'b0;
  logic  reset = 1'b0;
  logic  cpu_valid = 1'b0;
  logic  cpu_fence = 1'b0;
  addr_t cpu_addr = '0;
  word_t cpu_wdata = '0;
  strb_t cpu_wstrb = '0;
  word_t cpu_rdata;
  logic  cpu_ready;
  logic  mem_valid;
  addr_t mem_addr;
  word_t mem_wdata;
  strb_t mem_wstrb;
  word_t mem_rdata = '0;
  logic  mem_ready = 1'b0;

  word_t backing [logic [29:0]];
  logic  mem_busy = 1'b0;
  int    mem_delay = 0;

  byte   op_q [$];
  addr_t addr_q [$];
  word_t data_q [$];
  strb_t strb_q [$];
  word_t expect_q [$];
  int    op_count = 0;
  bit    ops_loaded = 1'b0;
  int    error_count = 0;
  int    check_count = 0;

  dtim dut_i (
    .clock     (clock),
    .reset     (reset),
    .cpu_valid (cpu_valid),
    .cpu_fence (cpu_fence),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_wstrb (cpu_wstrb),
    .cpu_rdata (cpu_rdata),
    .cpu_ready (cpu_ready),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready)
  );

  always #2 clock = ~clock;

  function automatic word_t read_backing(logic [29:0] word_addr);
    if (backing.exists(word_addr)) begin
      return backing[word_addr];
    end
    return {2'b00, word_addr} ^ 32'h5a5a_0000; // Untouched words hold their word address XOR a fixed pattern.
  endfunction

  task automatic serve_mem();
    word_t word;
    word = read_backing(mem_addr[31:2]);
    if (mem_wstrb != '0) begin
      for (int i = 0; i < 4; i++) begin
        if (mem_wstrb[i]) begin
          word[8*i +: 8] = mem_wdata[8*i +: 8];
        end
      end
      backing[mem_addr[31:2]] = word;
      mem_rdata = '0;
    end else begin
      mem_rdata = word;
    end
    mem_ready = 1'b1;
  endtask

  // Backing memory answers after 0 to 3 idle cycles.
  initial begin
    void'($urandom(32'hca71_3f6f));
    forever begin
      @(negedge clock);
      if (!reset || mem_ready) begin
        mem_ready = 1'b0;
        mem_busy = 1'b0;
      end else if (mem_valid) begin
        if (!mem_busy) begin
          mem_busy = 1'b1;
          mem_delay = $urandom % 4;
        end
        if (mem_delay == 0) begin
          serve_mem();
        end else begin
          mem_delay--;
        end
      end
    end
  end

  task automatic load_stimulus();
    int    fd;
    int    code;
    string line;
    byte   op;
    addr_t addr;
    word_t data;
    strb_t strb;
    word_t expect_data;
    fd = $fopen("sim/dtim_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file sim/dtim_stimulus.txt.");
      error_count++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      code = $sscanf(line, "%c %h %h %h %h", op, addr, data, strb, expect_data);
      if (code != 5) begin
        $display("Could not parse stimulus line: %s", line);
        error_count++;
      end else begin
        op_q.push_back(op);
        addr_q.push_back(addr);
        data_q.push_back(data);
        strb_q.push_back(strb);
        expect_q.push_back(expect_data);
      end
    end
    $fclose(fd);
  endtask

  task automatic do_access(input byte op, input addr_t addr, input word_t data,
                           input strb_t strb, input word_t expect_data);
    int wait_cycles;
    @(negedge clock);
    cpu_valid = 1'b1;
    cpu_fence = (op == "F");
    cpu_addr = addr;
    cpu_wdata = data;
    cpu_wstrb = (op == "W") ? strb : '0;
    @(posedge clock); // This edge takes the request.
    wait_cycles = 0;
    do begin
      @(negedge clock);
      cpu_valid = 1'b0;
      @(posedge clock);
      wait_cycles++;
    end while (!cpu_ready);
    check_count++;
    if (cpu_rdata !== expect_data) begin
      $display("Fail at %0t: %c %h returned %h, expected %h", $time, op, addr,
               cpu_rdata, expect_data);
      error_count++;
    end
    if (op == "H" && wait_cycles != 1) begin
      $display("Fail at %0t: hit on %h took %0d cycles, expected 1", $time, addr,
               wait_cycles);
      error_count++;
    end
  endtask

  task automatic check_backing(input addr_t addr, input word_t expect_data);
    word_t word;
    word = read_backing(addr[31:2]);
    check_count++;
    if (word !== expect_data) begin
      $display("Fail at %0t: backing word %h holds %h, expected %h", $time, addr,
               word, expect_data);
      error_count++;
    end
  endtask

  initial begin
    wait (ops_loaded);
    repeat (op_count * (`DTIM_BANKS * `DTIM_SETS * 8 + 20)) @(posedge clock);
    $display("Run hung waiting for cpu_ready at %0t.", $time);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    load_stimulus();
    op_count = op_q.size();
    ops_loaded = 1'b1;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    for (int i = 0; i < op_count; i++) begin
      if (op_q[i] == "M") begin
        check_backing(addr_q[i], expect_q[i]);
      end else if (op_q[i] inside {"R", "H", "W", "F"}) begin
        do_access(op_q[i], addr_q[i], data_q[i], strb_q[i], expect_q[i]);
      end else begin
        $display("Stimulus entry %0d has an unknown op %c.", i, op_q[i]);
        error_count++;
      end
    end
    repeat (4) @(posedge clock);
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sim/dtim_stimulus.txt
# op addr data strb expected, all hex. R load, H load that must hit in one cycle,
# W store, F fence, M compare the backing memory word at addr with expected.
F 00000000 00000000 0 00000000
R 00000100 00000000 0 5a5a0040
H 00000100 00000000 0 5a5a0040
W 00000100 11223344 3 00000000
H 00000100 00000000 0 5a5a3344
W 00000100 aabbccdd 8 00000000
H 00000100 00000000 0 aa5a3344
W 00000204 99887766 6 00000000
H 00000204 00000000 0 5a887781
W 00020008 deadbeef f 00000000
M 00020008 00000000 0 deadbeef
R 00020008 00000000 0 deadbeef
R 00020010 00000000 0 5a5a8004
W 00001100 01020304 1 00000000
M 00001100 00000000 0 5a5a0404
R 00001100 00000000 0 5a5a0404
M 00000100 00000000 0 5a5a0040
F 00000000 00000000 0 00000000
M 00000100 00000000 0 aa5a3344
M 00000204 00000000 0 5a887781
M 00001100 00000000 0 5a5a0404
R 00000100 00000000 0 aa5a3344
H 00000100 00000000 0 aa5a3344
R 00000204 00000000 0 5a887781
H 00000204 00000000 0 5a887781
R 0000fffc 00000000 0 5a5a3fff
W 0000fffc 12345678 c 00000000
H 0000fffc 00000000 0 12343fff
R 00010000 00000000 0 5a5a4000
F 00000000 00000000 0 00000000
M 0000fffc 00000000 0 12343fff
R 0000fffc 00000000 0 12343fff
R 00001100 00000000 0 5a5a0404
H 00001100 00000000 0 5a5a0404

//--- vlog.f
+incdir+design
design/dtim_pkg.sv
design/dtim_ram.sv
design/dtim_ctrl.sv
design/dtim.sv
sim/dtim_sva.sv
sim/dtim_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := dtim_tb
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

# Pass or fail comes from the pass line in the simulator output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
